// ==== rtl/fpslice_pkg.sv ====
// ----------------------------------------------------------------------
// FP non-computational slice package
// Formats, operations, status flags and the payloads that travel the pipes
// ----------------------------------------------------------------------
package fpslice_pkg;

  // ----------------------------------------------------------------------
  // Widths and depths
  // ----------------------------------------------------------------------
  localparam int unsigned WIDTH       = 32;  // Operand and result word
  localparam int unsigned FP32_W      = 32;
  localparam int unsigned FP16_W      = 16;
  localparam int unsigned FP32_MAN    = 23;  // Mantissa bits, hidden bit excluded
  localparam int unsigned FP16_MAN    = 10;
  localparam int unsigned NUM_LANES   = 2;
  localparam int unsigned PIPE_STAGES = 2;

  // Canonical quiet NaNs
  localparam logic [FP32_W-1:0] QNAN32 = 32'h7FC0_0000;
  localparam logic [FP16_W-1:0] QNAN16 = 16'h7E00;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  typedef logic [7:0] tag_t;

  // IEEE 754 exception flags
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // What one lane hands to the output packer
  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
    logic             active;  // Lane counts towards the result
  } lane_pay_t;

  // Side information carried next to the lanes
  typedef struct packed {
    tag_t    tag;
    fp_fmt_e fmt;
    logic    vectorial;  // Only ever set for FP16
  } meta_t;

endpackage

// ==== rtl/slice_pipe.sv ====
// ----------------------------------------------------------------------
// Valid/ready pipeline of fixed depth with synchronous flush
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module slice_pipe #(
  parameter type PayloadType = logic
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  PayloadType in_data_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output PayloadType out_data_o,
  output logic       busy_o
);

  localparam int unsigned NS = fpslice_pkg::PIPE_STAGES;

  logic       valid_q [NS];
  PayloadType data_q  [NS];
  logic       ready_s [NS+1];  // Stage i may load when ready_s[i] is high

  assign ready_s[NS] = out_ready_i;  // Driven from downstream

  for (genvar i = 0; i < NS; i++) begin : gen_stage
    logic       src_valid;
    PayloadType src_data;

    if (i == 0) begin : gen_first
      assign src_valid = in_valid_i;
      assign src_data  = in_data_i;
    end else begin : gen_next
      assign src_valid = valid_q[i-1];
      assign src_data  = data_q[i-1];
    end

    // Advance if the next stage takes our item or this stage holds a bubble
    assign ready_s[i] = ready_s[i+1] | ~valid_q[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i] <= 1'b0;
      end else if (ready_s[i]) begin
        valid_q[i] <= src_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready_s[i] && src_valid) begin
        data_q[i] <= src_data;
      end
    end
  end

  assign in_ready_o  = ready_s[0];
  assign out_valid_o = valid_q[NS-1];
  assign out_data_o  = data_q[NS-1];

  always_comb begin : busy_level
    busy_o = 1'b0;
    for (int i = 0; i < NS; i++) begin
      busy_o |= valid_q[i];
    end
  end

  // A stalled output item must not change under the consumer
  a_stall_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

// ==== rtl/noncomp_lane.sv ====
// ----------------------------------------------------------------------
// Non-computational lane: sign injection and min/max, then its pipeline
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module noncomp_lane #(
  parameter int unsigned LANE_WIDTH = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic [LANE_WIDTH-1:0]  a_i,
  input  logic [LANE_WIDTH-1:0]  b_i,
  input  fpslice_pkg::op_e       op_i,
  input  fpslice_pkg::fp_fmt_e   fmt_i,
  input  logic                   active_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output fpslice_pkg::lane_pay_t pay_o,
  output logic                   busy_o
);

  logic [fpslice_pkg::FP32_W-1:0] a_w, b_w;        // Operands widened to FP32 size
  logic [fpslice_pkg::FP32_W-2:0] mag_a, mag_b;
  logic [fpslice_pkg::FP32_W-1:0] sgnj_res, minmax_res;
  logic                           is_half;
  logic                           sign_a, sign_b, nan_a, nan_b, snan_a, snan_b;
  logic                           inj_sign, a_lt_b, pick_a, is_minmax;
  fpslice_pkg::lane_pay_t         lane_res;

  // A 16-bit lane only ever sees FP16
  assign is_half   = (LANE_WIDTH == fpslice_pkg::FP16_W) || (fmt_i == fpslice_pkg::FMT_FP16);
  assign is_minmax = (op_i == fpslice_pkg::OP_MIN) || (op_i == fpslice_pkg::OP_MAX);

  always_comb begin : widen
    a_w = '0;
    b_w = '0;
    a_w[LANE_WIDTH-1:0] = a_i;
    b_w[LANE_WIDTH-1:0] = b_i;
  end

  // ----------------------------------------------------------------------
  // Operand classification
  // ----------------------------------------------------------------------
  always_comb begin : classify
    if (is_half) begin
      sign_a = a_w[fpslice_pkg::FP16_W-1];
      sign_b = b_w[fpslice_pkg::FP16_W-1];
      mag_a  = {16'b0, a_w[fpslice_pkg::FP16_W-2:0]};
      mag_b  = {16'b0, b_w[fpslice_pkg::FP16_W-2:0]};
      nan_a  = (&a_w[fpslice_pkg::FP16_W-2:fpslice_pkg::FP16_MAN]) &&
               (|a_w[fpslice_pkg::FP16_MAN-1:0]);
      nan_b  = (&b_w[fpslice_pkg::FP16_W-2:fpslice_pkg::FP16_MAN]) &&
               (|b_w[fpslice_pkg::FP16_MAN-1:0]);
      snan_a = nan_a && !a_w[fpslice_pkg::FP16_MAN-1];  // Quiet bit clear
      snan_b = nan_b && !b_w[fpslice_pkg::FP16_MAN-1];
    end else begin
      sign_a = a_w[fpslice_pkg::FP32_W-1];
      sign_b = b_w[fpslice_pkg::FP32_W-1];
      mag_a  = a_w[fpslice_pkg::FP32_W-2:0];
      mag_b  = b_w[fpslice_pkg::FP32_W-2:0];
      nan_a  = (&a_w[fpslice_pkg::FP32_W-2:fpslice_pkg::FP32_MAN]) &&
               (|a_w[fpslice_pkg::FP32_MAN-1:0]);
      nan_b  = (&b_w[fpslice_pkg::FP32_W-2:fpslice_pkg::FP32_MAN]) &&
               (|b_w[fpslice_pkg::FP32_MAN-1:0]);
      snan_a = nan_a && !a_w[fpslice_pkg::FP32_MAN-1];
      snan_b = nan_b && !b_w[fpslice_pkg::FP32_MAN-1];
    end
  end

  always_comb begin : sign_inject
    case (op_i)
      fpslice_pkg::OP_SGNJN: inj_sign = ~sign_b;
      fpslice_pkg::OP_SGNJX: inj_sign = sign_a ^ sign_b;
      default:               inj_sign = sign_b;
    endcase
    sgnj_res = a_w;  // Magnitude of a
    if (is_half) begin
      sgnj_res[fpslice_pkg::FP16_W-1] = inj_sign;
    end else begin
      sgnj_res[fpslice_pkg::FP32_W-1] = inj_sign;
    end
  end

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin : min_max
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
    pick_a = (op_i == fpslice_pkg::OP_MIN) ? a_lt_b : ~a_lt_b;

    if (nan_a && nan_b) begin
      minmax_res = is_half ? {16'b0, fpslice_pkg::QNAN16} : fpslice_pkg::QNAN32;
    end else if (nan_a) begin
      minmax_res = b_w;  // NaN loses against a number
    end else if (nan_b) begin
      minmax_res = a_w;
    end else begin
      minmax_res = pick_a ? a_w : b_w;
    end
  end

  always_comb begin : lane_result
    lane_res           = '0;
    lane_res.result    = is_minmax ? minmax_res : sgnj_res;
    lane_res.status.nv = is_minmax && (snan_a || snan_b);  // Only signalling NaNs raise
    lane_res.active    = active_i;
  end

  slice_pipe #(
    .PayloadType ( fpslice_pkg::lane_pay_t )
  ) u_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_data_i   ( lane_res    ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( pay_o       ),
    .busy_o      ( busy_o      )
  );

  a_op_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> op_i inside {fpslice_pkg::OP_SGNJ, fpslice_pkg::OP_SGNJN,
                                fpslice_pkg::OP_SGNJX, fpslice_pkg::OP_MIN,
                                fpslice_pkg::OP_MAX});

endmodule

// ==== rtl/result_packer.sv ====
// ----------------------------------------------------------------------
// Result packer: joins lane results by format and merges lane status
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module result_packer (
  input  fpslice_pkg::lane_pay_t       lane0_i,
  input  fpslice_pkg::lane_pay_t       lane1_i,
  input  fpslice_pkg::meta_t           meta_i,
  output logic [fpslice_pkg::WIDTH-1:0] result_o,
  output fpslice_pkg::status_t         status_o
);

  localparam int unsigned HW = fpslice_pkg::FP16_W;
  localparam int unsigned SW = $bits(fpslice_pkg::status_t);

  logic [SW-1:0] lane0_stat, lane1_stat;

  // ----------------------------------------------------------------------
  // Result word
  // ----------------------------------------------------------------------
  always_comb begin : pack
    if (meta_i.fmt == fpslice_pkg::FMT_FP32) begin
      result_o = lane0_i.result;
    end else if (meta_i.vectorial) begin
      // Lane 1 holds the upper element
      result_o = {lane1_i.result[HW-1:0], lane0_i.result[HW-1:0]};
    end else begin
      result_o = {{HW{1'b1}}, lane0_i.result[HW-1:0]};  // NaN-boxed scalar
    end
  end

  // ----------------------------------------------------------------------
  // Status
  // ----------------------------------------------------------------------
  // Idle lanes still compute, their flags are dropped here
  assign lane0_stat = lane0_i.status & {SW{lane0_i.active}};
  assign lane1_stat = lane1_i.status & {SW{lane1_i.active}};

  assign status_o = fpslice_pkg::status_t'(lane0_stat | lane1_stat);

endmodule

// ==== rtl/fp_noncomp_slice.sv ====
// ----------------------------------------------------------------------
// Two-lane FP non-computational slice for FP32 and scalar/vector FP16
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fp_noncomp_slice (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [fpslice_pkg::WIDTH-1:0] operand_a_i,
  input  logic [fpslice_pkg::WIDTH-1:0] operand_b_i,
  input  fpslice_pkg::op_e              op_i,
  input  fpslice_pkg::fp_fmt_e          fmt_i,
  input  logic                          vectorial_i,
  input  fpslice_pkg::tag_t             tag_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  output logic [fpslice_pkg::WIDTH-1:0] result_o,
  output fpslice_pkg::status_t          status_o,
  output fpslice_pkg::tag_t             tag_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  localparam int unsigned W  = fpslice_pkg::WIDTH;
  localparam int unsigned HW = fpslice_pkg::FP16_W;
  localparam int unsigned NL = fpslice_pkg::NUM_LANES;

  logic [NL-1:0]          lane_ready, lane_valid, lane_busy;
  fpslice_pkg::lane_pay_t lane0_pay, lane1_pay;
  logic [W-1:0]           lane0_a, lane0_b;
  logic                   vec_op;
  fpslice_pkg::meta_t     meta_in, meta_out;
  logic                   meta_ready, meta_valid, meta_busy;

  // ----------------------------------------------------------------------
  // Input side
  // ----------------------------------------------------------------------
  assign vec_op = vectorial_i && (fmt_i == fpslice_pkg::FMT_FP16);  // FP32 is never a vector

  // Lane 0 sees the whole word for FP32, the low element for FP16
  assign lane0_a = (fmt_i == fpslice_pkg::FMT_FP32) ? operand_a_i
                                                    : {{(W-HW){1'b0}}, operand_a_i[HW-1:0]};
  assign lane0_b = (fmt_i == fpslice_pkg::FMT_FP32) ? operand_b_i
                                                    : {{(W-HW){1'b0}}, operand_b_i[HW-1:0]};

  assign meta_in = '{tag: tag_i, fmt: fmt_i, vectorial: vec_op};

  assign in_ready_o = lane_ready[0];  // All pipes move together

  noncomp_lane #(
    .LANE_WIDTH ( W )
  ) lane0 (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .flush_i     ( flush_i       ),
    .in_valid_i  ( in_valid_i    ),
    .in_ready_o  ( lane_ready[0] ),
    .a_i         ( lane0_a       ),
    .b_i         ( lane0_b       ),
    .op_i        ( op_i          ),
    .fmt_i       ( fmt_i         ),
    .active_i    ( 1'b1          ),
    .out_valid_o ( lane_valid[0] ),
    .out_ready_i ( out_ready_i   ),
    .pay_o       ( lane0_pay     ),
    .busy_o      ( lane_busy[0]  )
  );

  // Upper lane runs on every item, only vectors mark it active
  noncomp_lane #(
    .LANE_WIDTH ( HW )
  ) lane1 (
    .clk_i       ( clk_i               ),
    .rst_n_i     ( rst_n_i             ),
    .flush_i     ( flush_i             ),
    .in_valid_i  ( in_valid_i          ),
    .in_ready_o  ( lane_ready[1]       ),
    .a_i         ( operand_a_i[W-1:HW] ),
    .b_i         ( operand_b_i[W-1:HW] ),
    .op_i        ( op_i                ),
    .fmt_i       ( fmt_i               ),
    .active_i    ( vec_op              ),
    .out_valid_o ( lane_valid[1]       ),
    .out_ready_i ( out_ready_i         ),
    .pay_o       ( lane1_pay           ),
    .busy_o      ( lane_busy[1]        )
  );

  slice_pipe #(
    .PayloadType ( fpslice_pkg::meta_t )
  ) u_meta_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( meta_ready  ),
    .in_data_i   ( meta_in     ),
    .out_valid_o ( meta_valid  ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( meta_out    ),
    .busy_o      ( meta_busy   )
  );

  // ----------------------------------------------------------------------
  // Output side
  // ----------------------------------------------------------------------
  result_packer u_packer (
    .lane0_i  ( lane0_pay ),
    .lane1_i  ( lane1_pay ),
    .meta_i   ( meta_out  ),
    .result_o ( result_o  ),
    .status_o ( status_o  )
  );

  assign tag_o       = meta_out.tag;
  assign out_valid_o = lane_valid[0];
  assign busy_o      = (|lane_busy) | meta_busy;

  // Lockstep between both lanes and the meta pipe
  a_ready_lockstep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lane_ready[0] == lane_ready[1]) && (lane_ready[0] == meta_ready));
  a_valid_lockstep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lane_valid[0] == lane_valid[1]) && (lane_valid[0] == meta_valid));

endmodule

// ==== bench/slice_checker.sv ====
// ----------------------------------------------------------------------
// Checker for the FP non-computational slice: reference model,
// queue of expected results, comparison and error reporting
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module slice_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [31:0]          operand_a_i,
  input  logic [31:0]          operand_b_i,
  input  fpslice_pkg::op_e     op_i,
  input  fpslice_pkg::fp_fmt_e fmt_i,
  input  logic                 vectorial_i,
  input  fpslice_pkg::tag_t    tag_i,
  input  logic                 in_valid_i,
  input  logic                 in_ready_i,
  input  logic                 flush_i,
  input  logic [31:0]          result_i,
  input  fpslice_pkg::status_t status_i,
  input  fpslice_pkg::tag_t    out_tag_i,
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  logic                 busy_i,
  output int                   errors_o,
  output int                   checks_o,
  output int                   pending_o
);

  typedef struct packed {
    logic [31:0]          result;
    fpslice_pkg::status_t status;
    fpslice_pkg::tag_t    tag;
    int unsigned          cycle;  // Edge on which the input was accepted
  } exp_t;

  exp_t                 exp_q[$];
  int                   errors = 0;
  int                   checks = 0;
  int unsigned          cycle = 0;
  int unsigned          last_stall = 0;
  logic                 idle_due = 1'b0;
  logic                 held_valid = 1'b0;
  logic [31:0]          held_result;
  fpslice_pkg::status_t held_status;
  fpslice_pkg::tag_t    held_tag;

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // One element, returns {nv, result}
  function automatic logic [32:0] model_elem(fpslice_pkg::op_e op, logic [31:0] x,
                                             logic [31:0] y, logic half);
    logic        sx, sy, nan_x, nan_y, snan_x, snan_y, sign;
    logic [30:0] mx, my;
    logic [31:0] key_x, key_y, res, qnan;
    if (half) begin
      sx     = x[15];
      sy     = y[15];
      mx     = {16'b0, x[14:0]};
      my     = {16'b0, y[14:0]};
      nan_x  = (x[14:10] == 5'h1f) && (x[9:0] != 10'h0);
      nan_y  = (y[14:10] == 5'h1f) && (y[9:0] != 10'h0);
      snan_x = nan_x && !x[9];
      snan_y = nan_y && !y[9];
      qnan   = 32'h0000_7e00;
    end else begin
      sx     = x[31];
      sy     = y[31];
      mx     = x[30:0];
      my     = y[30:0];
      nan_x  = (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
      nan_y  = (y[30:23] == 8'hff) && (y[22:0] != 23'h0);
      snan_x = nan_x && !x[22];
      snan_y = nan_y && !y[22];
      qnan   = 32'h7fc0_0000;
    end
    // Unsigned key that orders like the real line, -0 below +0
    key_x = {~sx, sx ? ~mx : mx};
    key_y = {~sy, sy ? ~my : my};
    case (op)
      fpslice_pkg::OP_SGNJ:  sign = sy;
      fpslice_pkg::OP_SGNJN: sign = ~sy;
      fpslice_pkg::OP_SGNJX: sign = sx ^ sy;
      default:               sign = 1'b0;
    endcase
    if (op != fpslice_pkg::OP_MIN && op != fpslice_pkg::OP_MAX) begin
      res = x;
      if (half) res[15] = sign;
      else      res[31] = sign;
      return {1'b0, res};
    end
    if (nan_x && nan_y)             res = qnan;
    else if (nan_x)                 res = y;
    else if (nan_y)                 res = x;
    else if (op == fpslice_pkg::OP_MIN) res = (key_x < key_y) ? x : y;
    else                            res = (key_x > key_y) ? x : y;
    return {snan_x || snan_y, res};
  endfunction

  function automatic exp_t expect_item(logic [31:0] a, logic [31:0] b, fpslice_pkg::op_e op,
                                       fpslice_pkg::fp_fmt_e fmt, logic vec,
                                       fpslice_pkg::tag_t tag, int unsigned cyc);
    exp_t        e;
    logic [32:0] lo, hi;
    e       = '0;
    e.tag   = tag;
    e.cycle = cyc;
    if (fmt == fpslice_pkg::FMT_FP32) begin
      lo          = model_elem(op, a, b, 1'b0);
      e.result    = lo[31:0];
      e.status.nv = lo[32];
    end else begin
      lo = model_elem(op, {16'h0, a[15:0]}, {16'h0, b[15:0]}, 1'b1);
      hi = model_elem(op, {16'h0, a[31:16]}, {16'h0, b[31:16]}, 1'b1);
      if (vec) begin
        e.result    = {hi[15:0], lo[15:0]};
        e.status.nv = lo[32] | hi[32];
      end else begin
        e.result    = {16'hffff, lo[15:0]};  // Boxed scalar, upper half ignored
        e.status.nv = lo[32];
      end
    end
    return e;
  endfunction

  // ----------------------------------------------------------------------
  // Reporting helpers
  // ----------------------------------------------------------------------
  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // ----------------------------------------------------------------------
  // Watch the DUT ports on every edge
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin : watch
    exp_t head;
    cycle++;
    if (!rst_n_i || flush_i) begin
      exp_q.delete();  // Everything in flight is gone
      idle_due   = 1'b1;
      held_valid = 1'b0;
    end else begin
      if (idle_due) begin
        check_value("out_valid_o", {31'b0, out_valid_i}, 32'd0);
        check_value("busy_o", {31'b0, busy_i}, 32'd0);
        check_value("in_ready_o", {31'b0, in_ready_i}, 32'd1);
        idle_due = 1'b0;
      end
      if (held_valid) begin
        if (!out_valid_i) begin
          report_error("Output valid dropped while the output was stalled");
        end else begin
          check_value("result_o (stalled)", result_i, held_result);
          check_value("status_o (stalled)", {27'b0, status_i}, {27'b0, held_status});
          check_value("tag_o (stalled)", {24'b0, out_tag_i}, {24'b0, held_tag});
        end
      end
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          report_error("Result came out with no input pending");
        end else begin
          head = exp_q.pop_front();
          check_value("result_o", result_i, head.result);
          check_value("status_o", {27'b0, status_i}, {27'b0, head.status});
          check_value("tag_o", {24'b0, out_tag_i}, {24'b0, head.tag});
          // Exact latency only holds when no stall followed the input
          if (last_stall <= head.cycle) begin
            checks++;
            if (cycle - head.cycle != fpslice_pkg::PIPE_STAGES) begin
              report_error($sformatf("Result with tag %h took %0d cycles instead of %0d",
                                     head.tag, cycle - head.cycle, fpslice_pkg::PIPE_STAGES));
            end
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        exp_q.push_back(expect_item(operand_a_i, operand_b_i, op_i, fmt_i, vectorial_i,
                                    tag_i, cycle));
      end
      held_valid  = out_valid_i && !out_ready_i;
      held_result = result_i;
      held_status = status_i;
      held_tag    = out_tag_i;
    end
    if (!out_ready_i) last_stall = cycle;
    errors_o  = errors;
    checks_o  = checks;
    pending_o = exp_q.size();
  end

endmodule

// ==== bench/tb_top.sv ====
// ----------------------------------------------------------------------
// Testbench top for the FP non-computational slice: clock, reset,
// random stimulus with output stalls, flush and watchdog
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_top;

  localparam int unsigned CLK_PERIOD     = 10;
  localparam int unsigned DRIVE_DLY      = 1;
  localparam int unsigned RESET_CYCLES   = 3;
  localparam int unsigned SGNJ_CYCLES    = 200;
  localparam int unsigned MINMAX_CYCLES  = 300;
  localparam int unsigned LATENCY_CYCLES = 150;
  localparam int unsigned STALL_CYCLES   = 400;
  localparam int unsigned FILL_CYCLES    = 10;
  localparam int unsigned FLUSH_CYCLES   = 150;
  localparam int unsigned DRAIN_CYCLES   = 20;
  localparam int unsigned TOTAL_CYCLES   = RESET_CYCLES + SGNJ_CYCLES + MINMAX_CYCLES +
                                           LATENCY_CYCLES + STALL_CYCLES + FILL_CYCLES +
                                           FLUSH_CYCLES + DRAIN_CYCLES + 10;
  localparam int unsigned WATCHDOG_NS    = TOTAL_CYCLES * 4 * CLK_PERIOD;

  // Operation sets
  localparam int OPS_SGNJ   = 0;
  localparam int OPS_MINMAX = 1;
  localparam int OPS_ALL    = 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [31:0]          operand_a, operand_b, result;
  fpslice_pkg::op_e     op;
  fpslice_pkg::fp_fmt_e fmt;
  fpslice_pkg::tag_t    tag_in, tag_out;
  fpslice_pkg::status_t status;
  logic                 vectorial, in_valid, in_ready, flush, out_valid, out_ready, busy;
  logic                 fired;
  int                   errors, checks, pending;
  int                   errors_before = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fp_noncomp_slice DUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .operand_a_i ( operand_a ),
    .operand_b_i ( operand_b ),
    .op_i        ( op        ),
    .fmt_i       ( fmt       ),
    .vectorial_i ( vectorial ),
    .tag_i       ( tag_in    ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag_out   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  slice_checker u_checker (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .operand_a_i ( operand_a ),
    .operand_b_i ( operand_b ),
    .op_i        ( op        ),
    .fmt_i       ( fmt       ),
    .vectorial_i ( vectorial ),
    .tag_i       ( tag_in    ),
    .in_valid_i  ( in_valid  ),
    .in_ready_i  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_i    ( result    ),
    .status_i    ( status    ),
    .out_tag_i   ( tag_out   ),
    .out_valid_i ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_i      ( busy      ),
    .errors_o    ( errors    ),
    .checks_o    ( checks    ),
    .pending_o   ( pending   )
  );

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // FP16 value biased towards zeros, infinities and both NaN kinds
  function automatic logic [15:0] rand_half();
    logic [15:0] v;
    v = 16'($urandom);
    case ($urandom % 8)
      0: v = {v[15], 15'h0};
      1: v = {v[15], 5'h1f, 10'h0};
      2: v = {v[15], 5'h1f, 1'b1, v[8:0]};        // Quiet NaN
      3: v = {v[15], 5'h1f, 1'b0, v[8:1], 1'b1};  // Signalling, payload never zero
      default: ;
    endcase
    return v;
  endfunction

  function automatic logic [31:0] rand_single();
    logic [31:0] v;
    v = $urandom;
    case ($urandom % 8)
      0: v = {v[31], 31'h0};
      1: v = {v[31], 8'hff, 23'h0};
      2: v = {v[31], 8'hff, 1'b1, v[21:0]};
      3: v = {v[31], 8'hff, 1'b0, v[21:1], 1'b1};
      default: ;
    endcase
    return v;
  endfunction

  function automatic fpslice_pkg::op_e pick_op(int mode);
    int unsigned r;
    if (mode == OPS_SGNJ)        r = $urandom % 3;
    else if (mode == OPS_MINMAX) r = 3 + $urandom % 2;
    else                         r = $urandom % 5;
    case (r)
      0:       return fpslice_pkg::OP_SGNJ;
      1:       return fpslice_pkg::OP_SGNJN;
      2:       return fpslice_pkg::OP_SGNJX;
      3:       return fpslice_pkg::OP_MIN;
      default: return fpslice_pkg::OP_MAX;
    endcase
  endfunction

  task automatic new_item(int mode);
    fmt       = (($urandom % 2) != 0) ? fpslice_pkg::FMT_FP16 : fpslice_pkg::FMT_FP32;
    vectorial = ($urandom % 2) != 0;
    op        = pick_op(mode);
    tag_in    = 8'($urandom);
    if (fmt == fpslice_pkg::FMT_FP32) begin
      operand_a = rand_single();
      operand_b = rand_single();
    end else begin
      operand_a = {rand_half(), rand_half()};
      operand_b = {rand_half(), rand_half()};
    end
    in_valid = ($urandom % 4) != 0;
  endtask

  // Valid holds its item until accepted, ready is sampled mid-cycle
  task automatic run_traffic(int unsigned cycles, int mode, int unsigned stall_pct);
    repeat (cycles) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (fired || !in_valid) new_item(mode);
      out_ready = ($urandom % 100) >= stall_pct;
      @(negedge clk);
      fired = in_valid && in_ready;
    end
  endtask

  task automatic flush_pipe();
    @(posedge clk);
    #DRIVE_DLY;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    flush     = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    flush = 1'b0;
    fired = 1'b0;
  endtask

  task automatic report_test(string name);
    $display("test %-14s done: %0d errors, %0d checks so far", name,
             errors - errors_before, checks);
    errors_before = errors;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'hdd69dd1e));
    rst_n     = 1'b0;
    operand_a = '0;
    operand_b = '0;
    op        = fpslice_pkg::OP_SGNJ;
    fmt       = fpslice_pkg::FMT_FP32;
    vectorial = 1'b0;
    tag_in    = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    fired     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(posedge clk);  // Idle state is checked on this edge
    #DRIVE_DLY;
    report_test("reset_state");

    run_traffic(SGNJ_CYCLES, OPS_SGNJ, 25);
    report_test("sign_inject");
    run_traffic(MINMAX_CYCLES, OPS_MINMAX, 25);
    report_test("min_max");
    run_traffic(LATENCY_CYCLES, OPS_ALL, 0);
    report_test("latency");
    run_traffic(STALL_CYCLES, OPS_ALL, 50);
    report_test("random_stall");

    run_traffic(FILL_CYCLES, OPS_ALL, 100);  // Output blocked, pipe fills up
    flush_pipe();
    run_traffic(FLUSH_CYCLES, OPS_ALL, 30);
    report_test("flush");

    // Drain what is still in flight
    @(posedge clk);
    #DRIVE_DLY;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    #DRIVE_DLY;
    if (pending != 0) begin
      $display("ERROR %0d expected results never came out of the DUT", pending);
    end
    report_test("drain");

    $display("checks: %0d, errors: %0d, results lost: %0d", checks, errors, pending);
    if (errors == 0 && pending == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/fpslice_pkg.sv
rtl/slice_pipe.sv
rtl/noncomp_lane.sv
rtl/result_packer.sv
rtl/fp_noncomp_slice.sv
bench/slice_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the slice testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top \
    -Mdir obj_dir -o Vtb_top \
  && ./obj_dir/Vtb_top | tee /dev/stderr | grep -Fx '*** PASSED ***' > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
